// File: common/avalon_port_pkg.sv
package avalon_port_pkg;

	// host side widths of the 64-bit port
	typedef logic [28:0] addr_t;
	typedef logic [63:0] data_t;
	typedef logic [7:0]  byte_en_t;

	// legal bursts run from 1 to 255
	typedef logic [7:0]  burst_t;

	// one command as seen on the host bus
	typedef struct packed {
		logic   read;
		logic   write;
		addr_t  address;
		burst_t burstcount;
	} avl_cmd_t;

	// one write beat
	typedef struct packed {
		data_t    data;
		byte_en_t byteenable;
	} avl_wbeat_t;

endpackage

// File: common/sdram_cmd_pkg.sv
package sdram_cmd_pkg;

	// command port word, reserved zero fields left out
	typedef struct packed {
		avalon_port_pkg::burst_t burstcount;
		avalon_port_pkg::addr_t  address;
		logic                    write;
		logic                    read;
	} cmd_word_t;

	// write data port word
	typedef struct packed {
		avalon_port_pkg::byte_en_t byteenable;
		avalon_port_pkg::data_t    data;
	} wr_word_t;

	typedef logic [7:0] beat_cnt_t;

	// burst terminator states
	typedef enum logic [1:0] {
		idle,
		write_burst,
		pad_burst,
		hold
	} term_state_t;

endpackage

// File: design/reset_request_sync.sv
`timescale 1ns/1ps

module reset_request_sync #(
	parameter int INIT_HOLD_CYCLES = 16
) (
	input  logic clock,
	input  logic reset_out,
	input  logic reset_core_req,
	output logic term_req
);

	localparam int CNT_W = $clog2(INIT_HOLD_CYCLES + 2);

	logic [CNT_W-1:0] hold_cnt;
	logic             hold_active;
	logic             req_meta;

	assign hold_active = (hold_cnt != '0);

	// power-on hold, runs down once after reset
	always_ff @(posedge clock or posedge reset_out) begin
		if (reset_out) begin
			hold_cnt <= CNT_W'(INIT_HOLD_CYCLES);
		end else if (hold_active) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	// two flop synchronizer, set while in reset
	always_ff @(posedge clock or posedge reset_out) begin
		if (reset_out) begin
			req_meta <= 1'b1;
			term_req <= 1'b1;
		end else begin
			req_meta <= hold_active | reset_core_req;
			term_req <= req_meta;
		end
	end

endmodule

// File: terminator/burst_tracker.sv
`timescale 1ns/1ps

module burst_tracker (
	input  logic                     clock,
	input  logic                     reset_out,
	input  logic                     cmd_fire,
	input  logic                     beat_fire,
	input  avalon_port_pkg::burst_t  burstcount,
	input  logic                     is_write,
	output sdram_cmd_pkg::beat_cnt_t write_left
);

	sdram_cmd_pkg::beat_cnt_t load_value;

	// the command transfer of a write also carries its first beat
	assign load_value = sdram_cmd_pkg::beat_cnt_t'(burstcount) -
		sdram_cmd_pkg::beat_cnt_t'(beat_fire);

	always_ff @(posedge clock or posedge reset_out) begin
		if (reset_out) begin
			write_left <= '0;
		end else if (cmd_fire && is_write) begin
			write_left <= load_value;
		end else if (beat_fire && (write_left != '0)) begin
			write_left <= write_left - 1'b1;
		end
	end

endmodule

// File: terminator/safe_terminator.sv
`timescale 1ns/1ps

module safe_terminator (
	input  logic                        clock,
	input  logic                        reset_out,
	input  logic                        term_req,
	input  avalon_port_pkg::addr_t      address,
	input  avalon_port_pkg::burst_t     burstcount,
	input  logic                        read,
	input  logic                        write,
	input  avalon_port_pkg::data_t      writedata,
	input  avalon_port_pkg::byte_en_t   byteenable,
	output logic                        waitrequest,
	input  logic                        readdatavalid,
	output logic                        cmd_valid,
	output avalon_port_pkg::avl_cmd_t   cmd,
	output logic                        beat_valid,
	output avalon_port_pkg::avl_wbeat_t beat,
	input  logic                        ready
);

	sdram_cmd_pkg::term_state_t state;
	sdram_cmd_pkg::term_state_t state_next;
	sdram_cmd_pkg::beat_cnt_t   write_left;
	logic                       cmd_fire;
	logic                       beat_fire;
	logic                       last_beat;

	assign cmd_fire  = cmd_valid & ready;
	assign beat_fire = beat_valid & ready;
	assign last_beat = beat_fire && (write_left == 8'd1);

	burst_tracker u_tracker (
		.clock(clock),
		.reset_out(reset_out),
		.cmd_fire(cmd_fire),
		.beat_fire(beat_fire),
		.burstcount(burstcount),
		.is_write(write),
		.write_left(write_left)
	);

	// command fields always follow the host
	assign cmd.read       = read;
	assign cmd.write      = write;
	assign cmd.address    = address;
	assign cmd.burstcount = burstcount;

	////////////////////////////////////////////////////////////////////////////
	// host handshake per state
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		cmd_valid       = 1'b0;
		beat_valid      = 1'b0;
		beat.data       = writedata;
		beat.byteenable = byteenable;
		waitrequest     = 1'b1;
		case (state)
			sdram_cmd_pkg::idle: begin
				cmd_valid   = (read | write) & ~term_req;
				beat_valid  = write & ~term_req;
				waitrequest = term_req | ~ready;
			end
			sdram_cmd_pkg::write_burst: begin
				beat_valid  = write & ~term_req;
				waitrequest = term_req | ~ready;
			end
			sdram_cmd_pkg::pad_burst: begin
				// host is stalled, finish the burst with empty beats
				beat_valid      = 1'b1;
				beat.data       = '0;
				beat.byteenable = '0;
			end
			default: begin
			end
		endcase
	end

	always_comb begin
		state_next = state;
		case (state)
			sdram_cmd_pkg::idle: begin
				if (term_req) begin
					state_next = sdram_cmd_pkg::hold;
				end else if (cmd_fire && write && (burstcount > 8'd1)) begin
					state_next = sdram_cmd_pkg::write_burst;
				end
			end
			sdram_cmd_pkg::write_burst: begin
				if (term_req) begin
					state_next = sdram_cmd_pkg::pad_burst;
				end else if (last_beat) begin
					state_next = sdram_cmd_pkg::idle;
				end
			end
			sdram_cmd_pkg::pad_burst: begin
				if (last_beat) begin
					state_next = sdram_cmd_pkg::hold;
				end
			end
			default: begin
				// let a returning read finish before taking commands again
				if (!term_req && !readdatavalid) begin
					state_next = sdram_cmd_pkg::idle;
				end
			end
		endcase
	end

	always_ff @(posedge clock or posedge reset_out) begin
		if (reset_out) begin
			state <= sdram_cmd_pkg::hold;
		end else begin
			state <= state_next;
		end
	end

endmodule

// File: design/cmd_packer.sv
`timescale 1ns/1ps

module cmd_packer (
	input  logic                        clock,
	input  logic                        reset_out,
	input  logic                        cmd_valid,
	input  avalon_port_pkg::avl_cmd_t   cmd,
	input  logic                        beat_valid,
	input  avalon_port_pkg::avl_wbeat_t beat,
	output logic                        ready,
	output logic                        out_cmd_valid,
	output sdram_cmd_pkg::cmd_word_t    out_cmd,
	output logic                        out_wr_valid,
	output sdram_cmd_pkg::wr_word_t     out_wr,
	input  logic                        cmd_ready,
	input  logic                        wr_ready
);

	// free once both halves are empty or leaving this cycle
	assign ready = (~out_cmd_valid | cmd_ready) & (~out_wr_valid | wr_ready);

	always_ff @(posedge clock or posedge reset_out) begin
		if (reset_out) begin
			out_cmd_valid <= 1'b0;
			out_wr_valid  <= 1'b0;
		end else if (ready) begin
			out_cmd_valid <= cmd_valid;
			out_wr_valid  <= beat_valid;
		end else begin
			if (cmd_ready) begin
				out_cmd_valid <= 1'b0;
			end
			if (wr_ready) begin
				out_wr_valid <= 1'b0;
			end
		end
	end

	// reorder into command port layout
	always_ff @(posedge clock) begin
		if (ready && cmd_valid) begin
			out_cmd.burstcount <= cmd.burstcount;
			out_cmd.address    <= cmd.address;
			out_cmd.write      <= cmd.write;
			out_cmd.read       <= cmd.read;
		end
		if (ready && beat_valid) begin
			out_wr.byteenable <= beat.byteenable;
			out_wr.data       <= beat.data;
		end
	end

endmodule

// File: backend/sdram_port_backend.sv
`timescale 1ns/1ps

module sdram_port_backend #(
	parameter int MEM_WORDS = 256
) (
	input  logic                     clock,
	input  logic                     reset_out,
	input  logic                     cmd_valid,
	input  sdram_cmd_pkg::cmd_word_t cmd,
	input  logic                     wr_valid,
	input  sdram_cmd_pkg::wr_word_t  wr,
	output logic                     cmd_ready,
	output logic                     wr_ready,
	output logic                     rd_valid,
	output avalon_port_pkg::data_t   rd_data
);

	localparam int AW = $clog2(MEM_WORDS);
	localparam int NB = $bits(avalon_port_pkg::byte_en_t);

	typedef enum logic [1:0] {
		port_idle,
		port_write,
		port_wait,
		port_read
	} port_state_t;

	avalon_port_pkg::data_t   mem [MEM_WORDS];
	port_state_t              state;
	sdram_cmd_pkg::beat_cnt_t wr_left;
	sdram_cmd_pkg::beat_cnt_t rd_left;
	logic [AW-1:0]            wr_addr;
	logic [AW-1:0]            rd_addr;
	logic [AW-1:0]            beat_addr;
	logic [1:0]               lat_seed;
	logic [1:0]               wait_cnt;
	logic                     cmd_fire;
	logic                     wr_fire;

	// first beat may ride along with its write command
	assign cmd_ready = (state == port_idle);
	assign wr_ready  = (state == port_write) || (cmd_ready && cmd_valid && cmd.write);
	assign cmd_fire  = cmd_valid & cmd_ready;
	assign wr_fire   = wr_valid & wr_ready;
	assign beat_addr = cmd_ready ? cmd.address[AW-1:0] : wr_addr;

	always_ff @(posedge clock or posedge reset_out) begin
		if (reset_out) begin
			state    <= port_idle;
			wr_left  <= '0;
			rd_left  <= '0;
			wait_cnt <= '0;
			lat_seed <= '0;
			rd_valid <= 1'b0;
		end else begin
			lat_seed <= lat_seed + 1'b1;
			rd_valid <= (state == port_read);
			case (state)
				port_idle: begin
					if (cmd_fire && cmd.write) begin
						wr_left <= cmd.burstcount - sdram_cmd_pkg::beat_cnt_t'(wr_fire);
						if (cmd.burstcount != sdram_cmd_pkg::beat_cnt_t'(wr_fire)) begin
							state <= port_write;
						end
					end else if (cmd_fire && cmd.read) begin
						// varying read latency
						rd_left  <= cmd.burstcount;
						wait_cnt <= lat_seed;
						state    <= port_wait;
					end
				end
				port_write: begin
					if (wr_fire) begin
						wr_left <= wr_left - 1'b1;
						if (wr_left == 8'd1) begin
							state <= port_idle;
						end
					end
				end
				port_wait: begin
					if (wait_cnt == '0) begin
						state <= port_read;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				default: begin
					rd_left <= rd_left - 1'b1;
					if (rd_left == 8'd1) begin
						state <= port_idle;
					end
				end
			endcase
		end
	end

	// addresses and data path
	always_ff @(posedge clock) begin
		if (wr_fire) begin
			wr_addr <= beat_addr + 1'b1;
			for (int i = 0; i < NB; i++) begin
				if (wr.byteenable[i]) begin
					mem[beat_addr][8*i +: 8] <= wr.data[8*i +: 8];
				end
			end
		end
		if (cmd_fire && cmd.read) begin
			rd_addr <= cmd.address[AW-1:0];
		end else if (state == port_read) begin
			rd_addr <= rd_addr + 1'b1;
			rd_data <= mem[rd_addr];
		end
	end

endmodule

// File: design/sysmem_lite.sv
`timescale 1ns/1ps

module sysmem_lite #(
	parameter int INIT_HOLD_CYCLES = 16,
	parameter int MEM_WORDS        = 256
) (
	input  logic                      clock,
	input  logic                      reset_out,
	input  logic                      reset_core_req,
	input  avalon_port_pkg::addr_t    address,
	input  avalon_port_pkg::burst_t   burstcount,
	input  logic                      read,
	input  logic                      write,
	input  avalon_port_pkg::data_t    writedata,
	input  avalon_port_pkg::byte_en_t byteenable,
	output logic                      waitrequest,
	output avalon_port_pkg::data_t    readdata,
	output logic                      readdatavalid
);

	logic                        term_req;
	logic                        cmd_valid;
	avalon_port_pkg::avl_cmd_t   cmd;
	logic                        beat_valid;
	avalon_port_pkg::avl_wbeat_t beat;
	logic                        ready;
	logic                        pk_cmd_valid;
	sdram_cmd_pkg::cmd_word_t    pk_cmd;
	logic                        pk_wr_valid;
	sdram_cmd_pkg::wr_word_t     pk_wr;
	logic                        bk_cmd_ready;
	logic                        bk_wr_ready;

	////////////////////////////////////////////////////////////////////////////
	// reset request conditioning
	////////////////////////////////////////////////////////////////////////////

	reset_request_sync #(
		.INIT_HOLD_CYCLES(INIT_HOLD_CYCLES)
	) u_reset_sync (
		.clock(clock),
		.reset_out(reset_out),
		.reset_core_req(reset_core_req),
		.term_req(term_req)
	);

	////////////////////////////////////////////////////////////////////////////
	// terminator, packer, memory port
	////////////////////////////////////////////////////////////////////////////

	safe_terminator u_terminator (
		.clock(clock),
		.reset_out(reset_out),
		.term_req(term_req),
		.address(address),
		.burstcount(burstcount),
		.read(read),
		.write(write),
		.writedata(writedata),
		.byteenable(byteenable),
		.waitrequest(waitrequest),
		.readdatavalid(readdatavalid),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.beat_valid(beat_valid),
		.beat(beat),
		.ready(ready)
	);

	cmd_packer u_packer (
		.clock(clock),
		.reset_out(reset_out),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.beat_valid(beat_valid),
		.beat(beat),
		.ready(ready),
		.out_cmd_valid(pk_cmd_valid),
		.out_cmd(pk_cmd),
		.out_wr_valid(pk_wr_valid),
		.out_wr(pk_wr),
		.cmd_ready(bk_cmd_ready),
		.wr_ready(bk_wr_ready)
	);

	sdram_port_backend #(
		.MEM_WORDS(MEM_WORDS)
	) u_backend (
		.clock(clock),
		.reset_out(reset_out),
		.cmd_valid(pk_cmd_valid),
		.cmd(pk_cmd),
		.wr_valid(pk_wr_valid),
		.wr(pk_wr),
		.cmd_ready(bk_cmd_ready),
		.wr_ready(bk_wr_ready),
		.rd_valid(readdatavalid),
		.rd_data(readdata)
	);

endmodule

// File: test/sysmem_lite_sva.sv
`timescale 1ns/1ps

module sysmem_lite_sva (
	input logic                        clock,
	input logic                        reset_out,
	input sdram_cmd_pkg::term_state_t  state,
	input logic                        waitrequest,
	input logic                        readdatavalid,
	input logic                        beat_valid,
	input avalon_port_pkg::avl_wbeat_t beat
);

	// bumped by every failing assertion
	int fail_count = 0;

	rdv_quiet_in_reset: assert property (@(posedge clock) reset_out |-> !readdatavalid)
	else begin
		fail_count++;
		$error("readdatavalid high during reset");
	end

	// host stays stalled while the FSM holds
	hold_stalls_host: assert property (@(posedge clock) disable iff (reset_out)
		(state == sdram_cmd_pkg::hold) |-> waitrequest)
	else begin
		fail_count++;
		$error("waitrequest low in hold");
	end

	// padding beats never touch memory
	pad_beats_empty: assert property (@(posedge clock) disable iff (reset_out)
		(state == sdram_cmd_pkg::pad_burst && beat_valid) |-> (beat.byteenable == '0))
	else begin
		fail_count++;
		$error("padded beat with byteenable set");
	end

endmodule

// File: test/sysmem_lite_tb.sv
`timescale 1ns/1ps

module sysmem_lite_tb;

	localparam int INIT_HOLD_CYCLES = 16;
	localparam int MEM_WORDS        = 256;
	localparam int RANDOM_BURSTS    = 24;
	localparam int STREAM_READS     = 16;
	// reset request timing for the cut write burst
	localparam int REQ_DELAY        = 3;
	localparam int SYNC_DELAY       = 2;

	logic                      clock;
	logic                      reset_out;
	logic                      reset_core_req;
	avalon_port_pkg::addr_t    address;
	avalon_port_pkg::burst_t   burstcount;
	logic                      read;
	logic                      write;
	avalon_port_pkg::data_t    writedata;
	avalon_port_pkg::byte_en_t byteenable;
	logic                      waitrequest;
	avalon_port_pkg::data_t    readdata;
	logic                      readdatavalid;

	// reference memory and the read words still owed by the DUT
	avalon_port_pkg::data_t model [int];
	avalon_port_pkg::data_t expect_q [$];
	int beats_issued   = 0;
	int cycle_count    = 0;

	sysmem_lite #(
		.INIT_HOLD_CYCLES(INIT_HOLD_CYCLES),
		.MEM_WORDS(MEM_WORDS)
	) UUT (
		.clock(clock),
		.reset_out(reset_out),
		.reset_core_req(reset_core_req),
		.address(address),
		.burstcount(burstcount),
		.read(read),
		.write(write),
		.writedata(writedata),
		.byteenable(byteenable),
		.waitrequest(waitrequest),
		.readdata(readdata),
		.readdatavalid(readdatavalid)
	);

	bind safe_terminator sysmem_lite_sva u_sva (
		.clock(clock),
		.reset_out(reset_out),
		.state(state),
		.waitrequest(waitrequest),
		.readdatavalid(readdatavalid),
		.beat_valid(beat_valid),
		.beat(beat)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	////////////////////////////////////////////////////////////////////////////
	// checks and model helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic fail_now(input string what);
		$display("%s", what);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input avalon_port_pkg::data_t got,
		input avalon_port_pkg::data_t exp);
		if (got !== exp) begin
			fail_now($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_count(input string name, input sdram_cmd_pkg::beat_cnt_t got,
		input sdram_cmd_pkg::beat_cnt_t exp);
		if (got !== exp) begin
			fail_now($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	// pattern covers every address bit
	function automatic avalon_port_pkg::data_t fill_word(input int a);
		avalon_port_pkg::addr_t wa;
		wa = avalon_port_pkg::addr_t'(a);
		return {3'b101, wa, 3'b010, ~wa};
	endfunction

	function automatic avalon_port_pkg::data_t merge_bytes(input avalon_port_pkg::data_t old,
		input avalon_port_pkg::data_t data, input avalon_port_pkg::byte_en_t be);
		avalon_port_pkg::data_t res;
		res = old;
		for (int i = 0; i < 8; i++) begin
			if (be[i]) begin
				res[8*i +: 8] = data[8*i +: 8];
			end
		end
		return res;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// host bus driver
	////////////////////////////////////////////////////////////////////////////

	task automatic write_burst(input int addr, input int len, input bit random_fill,
		input bit stop_on_wait, output int accepted, output int stalled);
		avalon_port_pkg::data_t    data;
		avalon_port_pkg::byte_en_t be;
		bit                        stopped;
		int                        k;
		accepted = 0;
		stalled  = 0;
		stopped  = 1'b0;
		beats_issued += len;
		data = random_fill ? {$urandom, $urandom} : fill_word(addr);
		be   = random_fill ? avalon_port_pkg::byte_en_t'($urandom) : 8'hff;
		@(posedge clock);
		address    <= avalon_port_pkg::addr_t'(addr);
		burstcount <= avalon_port_pkg::burst_t'(len);
		write      <= 1'b1;
		writedata  <= data;
		byteenable <= be;
		while (accepted < len && !stopped) begin
			@(negedge clock);
			if (!waitrequest) begin
				k = addr + accepted;
				model[k] = merge_bytes(model.exists(k) ? model[k] : '0, data, be);
				accepted++;
				data = random_fill ? {$urandom, $urandom} : fill_word(addr + accepted);
				be   = random_fill ? avalon_port_pkg::byte_en_t'($urandom) : 8'hff;
			end else if (stop_on_wait) begin
				stopped = 1'b1;
			end else begin
				stalled++;
			end
			@(posedge clock);
			writedata  <= data;
			byteenable <= be;
		end
		write <= 1'b0;
	endtask

	// expected words are taken when the command is accepted
	task automatic read_burst(input int addr, input int len);
		bit done;
		done = 1'b0;
		beats_issued += len;
		@(posedge clock);
		address    <= avalon_port_pkg::addr_t'(addr);
		burstcount <= avalon_port_pkg::burst_t'(len);
		read       <= 1'b1;
		while (!done) begin
			@(negedge clock);
			if (!waitrequest) begin
				if (reset_core_req) begin
					fail_now("read command accepted while the reset request was high");
				end
				for (int i = 0; i < len; i++) begin
					expect_q.push_back(model[addr + i]);
				end
				done = 1'b1;
			end
			@(posedge clock);
		end
		read <= 1'b0;
	endtask

	task automatic wait_reads_done();
		while (expect_q.size() != 0) begin
			@(negedge clock);
		end
		// a few quiet cycles to catch extra beats
		repeat (4) @(negedge clock);
	endtask

	always @(negedge clock) begin
		if (readdatavalid) begin
			if (expect_q.size() == 0) begin
				fail_now("readdatavalid high with no read beat outstanding");
			end else begin
				check_data("readdata", readdata, expect_q.pop_front());
			end
		end
	end

	// bound assertions count their failures
	always @(negedge clock) begin
		if (UUT.u_terminator.u_sva.fail_count != 0) begin
			fail_now("assertion failed in the burst terminator");
		end
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count > 40 * beats_issued + INIT_HOLD_CYCLES) begin
			fail_now($sformatf("timeout after %0d cycles", cycle_count));
		end
	end

	initial begin
		int accepted;
		int stalled;
		int addr;
		int len;
		void'($urandom(70));
		reset_out      = 1'b1;
		reset_core_req = 1'b0;
		address        = '0;
		burstcount     = '0;
		read           = 1'b0;
		write          = 1'b0;
		writedata      = '0;
		byteenable     = '0;
		repeat (4) @(posedge clock);
		reset_out <= 1'b0;

		// fill memory, the first burst waits out the power-on hold
		for (int a = 0; a < MEM_WORDS; a += 8) begin
			write_burst(a, 8, 1'b0, 1'b0, accepted, stalled);
			if (a == 0 && stalled < INIT_HOLD_CYCLES) begin
				fail_now("waitrequest dropped before the power-on hold ended");
			end
		end

		// random writes, each read back
		for (int n = 0; n < RANDOM_BURSTS; n++) begin
			len  = 1 + int'($urandom % 8);
			addr = int'($urandom % (MEM_WORDS - 8));
			write_burst(addr, len, 1'b1, 1'b0, accepted, stalled);
			read_burst(addr, len);
		end
		wait_reads_done();

		// back to back reads under back-pressure
		for (int n = 0; n < STREAM_READS; n++) begin
			len  = 1 + int'($urandom % 8);
			addr = int'($urandom % (MEM_WORDS - 8));
			read_burst(addr, len);
		end
		wait_reads_done();

		// reset request in the middle of a write burst
		addr = int'($urandom % (MEM_WORDS - 8));
		fork
			write_burst(addr, 8, 1'b1, 1'b1, accepted, stalled);
			begin
				repeat (REQ_DELAY) @(posedge clock);
				reset_core_req <= 1'b1;
				repeat (12) @(posedge clock);
				reset_core_req <= 1'b0;
			end
		join
		// host beats stop once term_req follows the request
		check_count("accepted beats", sdram_cmd_pkg::beat_cnt_t'(accepted),
			sdram_cmd_pkg::beat_cnt_t'(REQ_DELAY - 1 + SYNC_DELAY));
		read_burst(addr, 9);
		wait_reads_done();

		// read accepted right before a reset request
		addr = int'($urandom % (MEM_WORDS - 8));
		read_burst(addr, 8);
		reset_core_req <= 1'b1;
		fork
			begin
				repeat (4) @(posedge clock);
				read_burst(int'($urandom % (MEM_WORDS - 8)), 4);
			end
			begin
				repeat (20) @(posedge clock);
				reset_core_req <= 1'b0;
			end
		join
		wait_reads_done();

		if (UUT.u_terminator.u_sva.fail_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: compile.f
common/avalon_port_pkg.sv
common/sdram_cmd_pkg.sv
design/reset_request_sync.sv
terminator/burst_tracker.sv
terminator/safe_terminator.sv
design/cmd_packer.sv
backend/sdram_port_backend.sv
design/sysmem_lite.sv
test/sysmem_lite_sva.sv
test/sysmem_lite_tb.sv

// File: Makefile
# Verilator build and run of the sysmem_lite testbench

TOP := sysmem_lite_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary -Wno-fatal --top-module $(TOP) -f compile.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
